//--- flist.f
+incdir+rtl
rtl/ipv4_pkg.sv
rtl/arp_wb_pkg.sv
rtl/ipv4_hdr_decode.sv
rtl/ipv4_hdr_execute.sv
rtl/ipv4_frame_result.sv
rtl/ipv4_tx_top.sv
tb/ipv4_tx_clkgen.sv
tb/ipv4_tx_sva.sv
tb/ipv4_tx_tb.sv

//--- Bender.yml
package:
  name: ipv4_tx

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ipv4_pkg.sv
      - rtl/arp_wb_pkg.sv
      - rtl/ipv4_hdr_decode.sv
      - rtl/ipv4_hdr_execute.sv
      - rtl/ipv4_frame_result.sv
      - rtl/ipv4_tx_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/ipv4_tx_clkgen.sv
      - tb/ipv4_tx_sva.sv
      - tb/ipv4_tx_tb.sv

//--- tb/ipv4_tx_tb.sv
`timescale 1ns/10ps
`include "ipv4_tx_settings.svh"

module ipv4_tx_tb
  import ipv4_pkg::*, arp_wb_pkg::*;
();

  typedef struct packed {
    ipv4_req_t req;
    logic      arp_ok;
    logic      exp_err;
  } row_t;

  logic             clk;
  logic             fsm_rst;
  ipv4_addr_t       dev_ip;
  logic             req_val;
  ipv4_req_t        req;
  logic             req_acc;
  logic             wb_cyc;
  logic             wb_stb;
  logic [WB_AW-1:0] wb_adr;
  logic [WB_DW-1:0] wb_dat_i;
  logic             wb_ack;
  logic             mac_req;
  logic             frame_rdy;
  mac_addr_t        eth_dst_mac;
  ipv4_len_t        eth_len;
  logic             eth_val;
  logic             eth_sof;
  logic             eth_eof;
  logic [7:0]       eth_dat;
  logic             pld_rd;
  logic [7:0]       pld_dat;
  logic             tx_done;
  logic             tx_err;

  row_t       rows [6];
  mac_addr_t  arp_mac [32];
  logic       arp_valid [32];
  logic [7:0] adr_q [$];
  logic [7:0] pld_exp [$];
  logic       wb_cyc_seen;
  logic       wb_busy;
  logic [1:0] wb_wait;
  logic [15:0] lfsr_q;
  int         value_errors;
  int         timeout_errors;
  logic       aborted;

  ipv4_tx_clkgen u_clkgen (
    .clk     (clk),
    .fsm_rst (fsm_rst)
  );

  ipv4_tx_top UUT (.*);

  // ####################################################################
  // Helpers.
  // ####################################################################

  // Taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[6:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_errors++;
    aborted = 1'b1;
    $display("Timeout at %0t: no %s within its cycle limit", $time, what);
  endtask

  // Byte 0 of the wire order in bits 159:152.
  function automatic logic [159:0] expected_header(input ipv4_req_t rq, input logic [31:0] src);
    logic [159:0] h;
    logic [31:0]  sum;
    int k;
    h = {8'h45, rq.qos, rq.pld_len + 16'd20, rq.id, 1'b0, rq.df, rq.mf, rq.fo,
         rq.ttl, rq.proto, 16'h0000, src, rq.dst_ip};
    sum = '0;
    for (k = 0; k < 10; k++) begin
      sum = sum + h[159 - 16 * k -: 16];
    end
    sum = sum[15:0] + sum[31:16];
    sum = sum[15:0] + sum[31:16];
    h[79:64] = ~sum[15:0];
    return h;
  endfunction

  // Even words carry valid and MAC high, odd words MAC low.
  function automatic logic [31:0] arp_word(input logic [7:0] adr);
    logic [7:0] ofs;
    logic [4:0] ent;
    ofs = adr - `ARP_BASE;
    ent = 5'(ofs / `ARP_STRIDE);
    if (ofs % `ARP_STRIDE == 0) begin
      return {arp_valid[ent], 15'h0000, arp_mac[ent][47:32]};
    end
    return arp_mac[ent][31:0];
  endfunction

  function automatic row_t make_row(
    input logic [7:0]  qos,
    input logic [15:0] id,
    input logic        df,
    input logic        mf,
    input logic [12:0] fo,
    input logic [7:0]  ttl,
    input logic [7:0]  proto,
    input logic [31:0] dst,
    input logic [15:0] len,
    input logic        known,
    input logic [47:0] mac,
    input logic        arp_ok,
    input logic        exp_err
  );
    row_t rw;
    rw.req     = {qos, id, df, mf, fo, ttl, proto, dst, len, known, mac};
    rw.arp_ok  = arp_ok;
    rw.exp_err = exp_err;
    return rw;
  endfunction

  // ####################################################################
  // Bus and payload models.
  // ####################################################################

  always @(posedge clk) begin
    if (wb_cyc) begin
      wb_cyc_seen = 1'b1;
    end
    if (fsm_rst) begin
      wb_ack  <= 1'b0;
      wb_busy <= 1'b0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
    end else if (wb_busy) begin
      if (wb_wait == 2'd0) begin
        wb_ack   <= 1'b1;
        wb_dat_i <= arp_word(wb_adr);
        wb_busy  <= 1'b0;
      end else begin
        wb_wait <= wb_wait - 2'd1;
      end
    end else if (wb_cyc && wb_stb) begin
      // Ack 1 to 3 cycles later.
      adr_q.push_back(wb_adr);
      wb_wait <= 2'(rand_bits(2) % 3);
      wb_busy <= 1'b1;
    end
  end

  always @(posedge clk) begin : serve_payload
    logic [7:0] b;
    if (pld_rd) begin
      b = rand_bits(8);
      pld_dat <= b;
      pld_exp.push_back(b);
    end
  end

  // ####################################################################
  // Request sequence.
  // ####################################################################

  task automatic wait_reset_release();
    int t;
    t = 0;
    while (fsm_rst !== 1'b0 && t < 40) begin
      @(posedge clk);
      t++;
    end
    if (fsm_rst !== 1'b0) begin
      report_timeout("reset release");
    end
  endtask

  task automatic check_idle_outputs(input int cycles);
    int c;
    for (c = 0; c < cycles; c++) begin
      @(posedge clk);
      compare("control outputs before first request",
              {req_acc, wb_cyc, wb_stb, frame_rdy, eth_val, eth_sof, eth_eof,
               pld_rd, tx_done, tx_err}, '0);
    end
  endtask

  task automatic run_row(input int r);
    row_t         row;
    logic [159:0] hdr_exp;
    logic [4:0]   idx;
    logic [7:0]   base;
    int           exp_len;
    int           n;
    int           t;
    logic         seen;
    logic         got_rdy;
    logic         got_done;
    logic         last_eof;
    row = rows[r];
    idx = row.req.dst_ip[0][4:0];
    base = 8'(`ARP_BASE + idx * `ARP_STRIDE);
    arp_valid[idx] = row.arp_ok;
    exp_len = `IPV4_HDR_LEN + row.req.pld_len;
    hdr_exp = expected_header(row.req, dev_ip);
    adr_q.delete();
    pld_exp.delete();
    wb_cyc_seen = 1'b0;
    req     <= row.req;
    req_val <= 1'b1;
    t = 0;
    seen = 1'b0;
    while (!seen && t < 50) begin
      @(posedge clk);
      t++;
      seen = req_acc;
    end
    if (!seen) begin
      report_timeout("req_acc");
      return;
    end
    // Scrambled fields must not reach the header.
    req_val <= 1'b0;
    req     <= '1;
    t = 0;
    got_rdy = 1'b0;
    got_done = 1'b0;
    while (!got_rdy && !got_done && t < 400) begin
      @(posedge clk);
      t++;
      compare($sformatf("row %0d eth_val before handshake", r), eth_val, 1'b0);
      got_rdy = frame_rdy;
      got_done = tx_done;
    end
    if (!got_rdy && !got_done) begin
      report_timeout("frame_rdy or tx_done");
      return;
    end
    if (got_done) begin
      compare($sformatf("row %0d lookup miss", r), 1'b1, row.exp_err);
      compare($sformatf("row %0d tx_err with tx_done", r), tx_err, 1'b1);
      compare($sformatf("row %0d ARP reads on miss", r), adr_q.size(), 1);
      if (adr_q.size() > 0) begin
        compare($sformatf("row %0d wb_adr word 0", r), adr_q[0], base);
      end
      return;
    end
    compare($sformatf("row %0d lookup miss", r), 1'b0, row.exp_err);
    compare($sformatf("row %0d eth_len", r), eth_len, exp_len);
    if (row.req.mac_known) begin
      compare($sformatf("row %0d eth_dst_mac", r), eth_dst_mac, row.req.mac);
      compare($sformatf("row %0d wb_cyc with known MAC", r), wb_cyc_seen, 1'b0);
    end else begin
      compare($sformatf("row %0d eth_dst_mac", r), eth_dst_mac, arp_mac[idx]);
      compare($sformatf("row %0d ARP reads", r), adr_q.size(), 2);
      if (adr_q.size() == 2) begin
        compare($sformatf("row %0d wb_adr word 0", r), adr_q[0], base);
        compare($sformatf("row %0d wb_adr word 1", r), adr_q[1], base + 8'd1);
      end
    end
    mac_req <= 1'b1;
    n = 0;
    t = 0;
    got_done = 1'b0;
    last_eof = 1'b0;
    while (!got_done && t < exp_len + 20) begin
      @(posedge clk);
      t++;
      mac_req <= 1'b0;
      if (eth_val) begin
        if (n < `IPV4_HDR_LEN) begin
          compare($sformatf("row %0d header byte %0d", r, n), eth_dat,
                  hdr_exp[159 - 8 * n -: 8]);
        end else if (n - `IPV4_HDR_LEN < pld_exp.size()) begin
          compare($sformatf("row %0d payload byte %0d", r, n - `IPV4_HDR_LEN), eth_dat,
                  pld_exp[n - `IPV4_HDR_LEN]);
        end else begin
          compare($sformatf("row %0d payload byte %0d read", r, n - `IPV4_HDR_LEN), 0, 1);
        end
        compare($sformatf("row %0d eth_sof at byte %0d", r, n), eth_sof, n == 0);
        compare($sformatf("row %0d eth_eof at byte %0d", r, n), eth_eof, n == exp_len - 1);
        n++;
      end else if (n > 0 && n < exp_len) begin
        compare($sformatf("row %0d eth_val held through frame", r), eth_val, 1'b1);
      end
      got_done = tx_done;
      if (tx_done) begin
        compare($sformatf("row %0d tx_done right after eof", r), last_eof, 1'b1);
        compare($sformatf("row %0d tx_err on sent frame", r), tx_err, 1'b0);
      end
      last_eof = eth_val && eth_eof;
    end
    if (!got_done) begin
      report_timeout("tx_done after frame");
      return;
    end
    compare($sformatf("row %0d frame byte count", r), n, exp_len);
    compare($sformatf("row %0d payload reads", r), pld_exp.size(), row.req.pld_len);
  endtask

  initial begin : run_all
    int r;
    int i;
    value_errors = 0;
    timeout_errors = 0;
    aborted = 1'b0;
    lfsr_q = 16'd51;
    wb_cyc_seen = 1'b0;
    wb_busy = 1'b0;
    wb_wait = 2'd0;
    dev_ip = 32'hC0A8_0001;
    req_val = 1'b0;
    req = '0;
    wb_dat_i = '0;
    wb_ack = 1'b0;
    mac_req = 1'b0;
    pld_dat = 8'h00;
    for (i = 0; i < 32; i++) begin
      arp_mac[i] = {16'h0250 + 16'(i), 32'hC3A5_0000 ^ (32'(i) * 32'h0001_0101)};
      arp_valid[i] = 1'b1;
    end
    // qos, id, df, mf, fo, ttl, proto, dst, len, known, mac, arp ok, expect miss.
    rows[0] = make_row(8'h00, 16'h1234, 1'b1, 1'b0, 13'h0000, 8'd64, 8'd17,
                       32'hC0A8_0105, 16'd8, 1'b1, 48'h0011_2233_4455, 1'b1, 1'b0);
    rows[1] = make_row(8'hB8, 16'hABCD, 1'b0, 1'b1, 13'h0123, 8'd128, 8'd6,
                       32'hC0A8_010A, 16'd0, 1'b0, 48'h0, 1'b1, 1'b0);
    rows[2] = make_row(8'h10, 16'h0001, 1'b0, 1'b0, 13'h0000, 8'd1, 8'd1,
                       32'h0A00_0013, 16'd5, 1'b0, 48'h0, 1'b0, 1'b1);
    rows[3] = make_row(8'h00, 16'hFFFF, 1'b1, 1'b0, 13'h1FFF, 8'hFF, 8'h11,
                       32'h0A00_001F, 16'd33, 1'b0, 48'h0, 1'b1, 1'b0);
    rows[4] = make_row(8'h28, 16'h0F0F, 1'b0, 1'b0, 13'h0040, 8'd32, 8'd17,
                       32'hC0A8_0107, 16'd1, 1'b1, 48'hA0B1_C2D3_E4F5, 1'b0, 1'b0);
    rows[5] = make_row(8'h04, 16'h8001, 1'b1, 1'b1, 13'h0001, 8'd10, 8'd6,
                       32'hAC10_2013, 16'd12, 1'b0, 48'h0, 1'b1, 1'b0);
    wait_reset_release();
    if (!aborted) begin
      check_idle_outputs(8);
    end
    for (r = 0; r < 6 && !aborted; r++) begin
      run_row(r);
    end
    repeat (5) @(posedge clk);
    $display("Error counts: %0d value, %0d timeout, %0d assertion",
             value_errors, timeout_errors, UUT.u_sva.fail_cnt);
    if (value_errors == 0 && timeout_errors == 0 && UUT.u_sva.fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- tb/ipv4_tx_sva.sv
`timescale 1ns/10ps

module ipv4_tx_sva (
  input logic clk,
  input logic fsm_rst,
  input logic req_acc,
  input logic wb_cyc,
  input logic wb_stb,
  input logic eth_val,
  input logic eth_sof,
  input logic eth_eof
);

  int fail_cnt = 0;

  // Frame markers only on valid bytes.
  a_marker_val : assert property (@(posedge clk) disable iff (fsm_rst)
    (eth_sof || eth_eof) |-> eth_val)
  else begin
    fail_cnt++;
    $error("eth_sof or eth_eof seen without eth_val");
  end

  a_stb_cyc : assert property (@(posedge clk) disable iff (fsm_rst)
    wb_stb |-> wb_cyc)
  else begin
    fail_cnt++;
    $error("wb_stb high outside a bus cycle");
  end

  // Accept is a single-cycle pulse.
  a_acc_pulse : assert property (@(posedge clk) disable iff (fsm_rst)
    req_acc |=> !req_acc)
  else begin
    fail_cnt++;
    $error("req_acc held longer than one cycle");
  end

endmodule

bind ipv4_tx_top ipv4_tx_sva u_sva (
  .clk     (clk),
  .fsm_rst (fsm_rst),
  .req_acc (req_acc),
  .wb_cyc  (wb_cyc),
  .wb_stb  (wb_stb),
  .eth_val (eth_val),
  .eth_sof (eth_sof),
  .eth_eof (eth_eof)
);

//--- tb/ipv4_tx_clkgen.sv
`timescale 1ns/10ps

module ipv4_tx_clkgen (
  output logic clk,
  output logic fsm_rst
);

  // 4 ns period.
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset held for ten rising edges.
  initial begin
    fsm_rst = 1'b1;
    repeat (10) @(posedge clk);
    fsm_rst <= 1'b0;
  end

endmodule

//--- rtl/ipv4_tx_top.sv
`timescale 1ns/10ps

module ipv4_tx_top
  import ipv4_pkg::*, arp_wb_pkg::*;
(
  input  logic             clk,
  input  logic             fsm_rst,
  input  ipv4_addr_t       dev_ip,
  input  logic             req_val,
  input  ipv4_req_t        req,
  output logic             req_acc,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic [WB_AW-1:0] wb_adr,
  input  logic [WB_DW-1:0] wb_dat_i,
  input  logic             wb_ack,
  input  logic             mac_req,
  output logic             frame_rdy,
  output mac_addr_t        eth_dst_mac,
  output ipv4_len_t        eth_len,
  output logic             eth_val,
  output logic             eth_sof,
  output logic             eth_eof,
  output logic [7:0]       eth_dat,
  output logic             pld_rd,
  input  logic [7:0]       pld_dat,
  output logic             tx_done,
  output logic             tx_err
);

  logic            start;
  ipv4_hdr_bytes_t hdr_bytes;
  ipv4_len_t       pld_len;
  logic            need_arp;
  mac_addr_t       known_mac;
  ipv4_addr_t      dst_ip;
  ipv4_hdr_bytes_t hdr_final;
  mac_addr_t       dst_mac;
  ipv4_len_t       frame_len;
  logic            ready;
  logic            miss;
  logic            done;

  ipv4_hdr_decode u_decode (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .dev_ip    (dev_ip),
    .req_val   (req_val),
    .req       (req),
    .req_acc   (req_acc),
    .done      (done),
    .start     (start),
    .hdr_bytes (hdr_bytes),
    .pld_len   (pld_len),
    .need_arp  (need_arp),
    .known_mac (known_mac),
    .dst_ip    (dst_ip)
  );

  ipv4_hdr_execute u_execute (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .start     (start),
    .hdr_bytes (hdr_bytes),
    .need_arp  (need_arp),
    .known_mac (known_mac),
    .dst_ip    (dst_ip),
    .pld_len   (pld_len),
    .done      (done),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack),
    .hdr_final (hdr_final),
    .dst_mac   (dst_mac),
    .frame_len (frame_len),
    .ready     (ready),
    .miss      (miss)
  );

  ipv4_frame_result u_result (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .ready       (ready),
    .miss        (miss),
    .hdr_final   (hdr_final),
    .dst_mac     (dst_mac),
    .frame_len   (frame_len),
    .mac_req     (mac_req),
    .frame_rdy   (frame_rdy),
    .eth_dst_mac (eth_dst_mac),
    .eth_len     (eth_len),
    .eth_val     (eth_val),
    .eth_sof     (eth_sof),
    .eth_eof     (eth_eof),
    .eth_dat     (eth_dat),
    .pld_rd      (pld_rd),
    .pld_dat     (pld_dat),
    .tx_done     (tx_done),
    .tx_err      (tx_err),
    .done        (done)
  );

endmodule

//--- rtl/ipv4_frame_result.sv
`timescale 1ns/10ps
`include "ipv4_tx_settings.svh"

module ipv4_frame_result
  import ipv4_pkg::*;
(
  input  logic            clk,
  input  logic            fsm_rst,
  input  logic            ready,
  input  logic            miss,
  input  ipv4_hdr_bytes_t hdr_final,
  input  mac_addr_t       dst_mac,
  input  ipv4_len_t       frame_len,
  input  logic            mac_req,
  output logic            frame_rdy,
  output mac_addr_t       eth_dst_mac,
  output ipv4_len_t       eth_len,
  output logic            eth_val,
  output logic            eth_sof,
  output logic            eth_eof,
  output logic [7:0]      eth_dat,
  output logic            pld_rd,
  input  logic [7:0]      pld_dat,
  output logic            tx_done,
  output logic            tx_err,
  output logic            done
);

  localparam logic [1:0] RES_IDLE = 2'd0;
  localparam logic [1:0] RES_RDY  = 2'd1;
  localparam logic [1:0] RES_STRM = 2'd2;
  localparam logic [1:0] RES_FIN  = 2'd3;

  logic [1:0]      res_st;
  ipv4_hdr_bytes_t shift_q;
  ipv4_len_t       cnt;
  logic [16:0]     cnt_ahead;
  logic            go;

  // Streaming starts on the edge that sees mac_req.
  assign go = (res_st == RES_STRM) || (res_st == RES_RDY && mac_req);

  // Payload reads run two bytes ahead of the output register.
  assign cnt_ahead = {1'b0, cnt} + 17'd2;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      res_st    <= RES_IDLE;
      frame_rdy <= 1'b0;
      eth_val   <= 1'b0;
      eth_sof   <= 1'b0;
      eth_eof   <= 1'b0;
      pld_rd    <= 1'b0;
      tx_done   <= 1'b0;
      tx_err    <= 1'b0;
      done      <= 1'b0;
    end else begin
      pld_rd  <= 1'b0;
      tx_done <= 1'b0;
      tx_err  <= 1'b0;
      done    <= 1'b0;
      case (res_st)
        RES_IDLE: begin
          if (ready) begin
            frame_rdy   <= 1'b1;
            eth_dst_mac <= dst_mac;
            eth_len     <= frame_len;
            shift_q     <= hdr_final;
            cnt         <= '0;
            res_st      <= RES_RDY;
          end else if (miss) begin
            tx_done <= 1'b1;
            tx_err  <= 1'b1;
            done    <= 1'b1;
          end
        end
        RES_RDY: begin
          if (mac_req) begin
            frame_rdy <= 1'b0;
            res_st    <= RES_STRM;
          end
        end
        RES_FIN: begin
          eth_val <= 1'b0;
          eth_sof <= 1'b0;
          eth_eof <= 1'b0;
          tx_done <= 1'b1;
          done    <= 1'b1;
          res_st  <= RES_IDLE;
        end
        default: ;
      endcase

      // ##################################################################
      // Byte serializer.
      // ##################################################################
      if (go) begin
        eth_val <= 1'b1;
        eth_sof <= (cnt == '0);
        eth_eof <= (cnt == eth_len - 1'b1);
        eth_dat <= (cnt < ipv4_len_t'(`IPV4_HDR_LEN)) ? shift_q[`IPV4_HDR_LEN-1] : pld_dat;
        shift_q <= {shift_q[`IPV4_HDR_LEN-2:0], 8'h00};
        cnt     <= cnt + 1'b1;
        pld_rd  <= (cnt_ahead >= 17'(`IPV4_HDR_LEN)) && (cnt_ahead < {1'b0, eth_len});
        if (cnt == eth_len - 1'b1) begin
          res_st <= RES_FIN;
        end
      end
    end
  end

endmodule

//--- rtl/ipv4_hdr_execute.sv
`timescale 1ns/10ps
`include "ipv4_tx_settings.svh"

module ipv4_hdr_execute
  import ipv4_pkg::*, arp_wb_pkg::*;
(
  input  logic             clk,
  input  logic             fsm_rst,
  input  logic             start,
  input  ipv4_hdr_bytes_t  hdr_bytes,
  input  logic             need_arp,
  input  mac_addr_t        known_mac,
  input  ipv4_addr_t       dst_ip,
  input  ipv4_len_t        pld_len,
  input  logic             done,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic [WB_AW-1:0] wb_adr,
  input  logic [WB_DW-1:0] wb_dat_i,
  input  logic             wb_ack,
  output ipv4_hdr_bytes_t  hdr_final,
  output mac_addr_t        dst_mac,
  output ipv4_len_t        frame_len,
  output logic             ready,
  output logic             miss
);

  localparam int NW = 2 ** `CKS_STAGES;
  localparam int LAST = `CKS_STAGES - 1;
  localparam int TMO_W = $clog2(`ARP_TIMEOUT);

  localparam logic [1:0] ARP_IDLE = 2'd0;
  localparam logic [1:0] ARP_RD0  = 2'd1;
  localparam logic [1:0] ARP_RD1  = 2'd2;
  localparam logic [1:0] ARP_HAVE = 2'd3;

  logic [NW-1:0][15:0]    words;
  logic [19:0]            tree [`CKS_STAGES][NW/2];
  logic [`CKS_STAGES-1:0] cks_vld;
  logic [16:0]            fold;
  logic [15:0]            cks;
  logic                   cks_ok;

  logic [1:0]             arp_st;
  logic [TMO_W-1:0]       tmo;
  logic [15:0]            mac_hi;
  logic [WB_AW-1:0]       entry_adr;
  arp_word_u              rd_word;

  // ####################################################################
  // Checksum adder tree.
  // ####################################################################

  assign words = {{(NW * 16 - $bits(hdr_bytes)){1'b0}}, hdr_bytes};

  for (genvar s = 0; s < `CKS_STAGES; s++) begin : g_stage
    for (genvar i = 0; i < (NW >> (s + 1)); i++) begin : g_add
      if (s == 0) begin : g_leaf
        always_ff @(posedge clk) begin
          tree[0][i] <= 20'(words[2*i]) + 20'(words[2*i+1]);
        end
      end else begin : g_node
        always_ff @(posedge clk) begin
          tree[s][i] <= tree[s-1][2*i] + tree[s-1][2*i+1];
        end
      end
    end
  end

  // Two folds absorb every carry.
  assign fold = {1'b0, tree[LAST][0][15:0]} + 17'(tree[LAST][0][19:16]);
  assign cks  = ~(fold[15:0] + 16'(fold[16]));

  always_ff @(posedge clk) begin
    if (cks_vld[LAST]) begin
      hdr_final <= {hdr_bytes[19:10], cks, hdr_bytes[7:0]};
      frame_len <= pld_len + ipv4_len_t'(`IPV4_HDR_LEN);
    end
  end

  // ####################################################################
  // ARP lookup as two classic reads per entry.
  // ####################################################################

  assign entry_adr = WB_AW'(`ARP_BASE)
                   + WB_AW'(dst_ip[0][`ARP_IDX_W-1:0]) * WB_AW'(`ARP_STRIDE);
  assign rd_word = wb_dat_i;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      arp_st  <= ARP_IDLE;
      wb_cyc  <= 1'b0;
      wb_stb  <= 1'b0;
      ready   <= 1'b0;
      miss    <= 1'b0;
      cks_ok  <= 1'b0;
      cks_vld <= '0;
    end else begin
      ready   <= 1'b0;
      miss    <= 1'b0;
      cks_vld <= {cks_vld[LAST-1:0], start};
      if (start) begin
        cks_ok <= 1'b0;
      end else if (cks_vld[LAST]) begin
        cks_ok <= 1'b1;
      end
      case (arp_st)
        ARP_IDLE: begin
          if (start && need_arp) begin
            arp_st <= ARP_RD0;
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_adr <= entry_adr;
            tmo    <= '0;
          end else if (start) begin
            arp_st  <= ARP_HAVE;
            dst_mac <= known_mac;
          end
        end
        ARP_RD0, ARP_RD1: begin
          if (!wb_cyc) begin
            // Second read opens a fresh bus cycle.
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            tmo    <= '0;
          end else if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            if (arp_st == ARP_RD1) begin
              dst_mac <= {mac_hi, rd_word.low.mac_lo};
              arp_st  <= ARP_HAVE;
            end else if (rd_word.status.valid) begin
              mac_hi <= rd_word.status.mac_hi;
              wb_adr <= wb_adr + 1'b1;
              arp_st <= ARP_RD1;
            end else begin
              miss   <= 1'b1;
              arp_st <= ARP_IDLE;
            end
          end else if (tmo == TMO_W'(`ARP_TIMEOUT - 1)) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            miss   <= 1'b1;
            arp_st <= ARP_IDLE;
          end else begin
            tmo <= tmo + 1'b1;
          end
        end
        ARP_HAVE: begin
          if (cks_ok || cks_vld[LAST]) begin
            ready  <= 1'b1;
            arp_st <= ARP_IDLE;
          end
        end
        default: arp_st <= ARP_IDLE;
      endcase
      if (done) begin
        arp_st <= ARP_IDLE;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
      end
    end
  end

endmodule

//--- rtl/ipv4_hdr_decode.sv
`timescale 1ns/10ps
`include "ipv4_tx_settings.svh"

module ipv4_hdr_decode
  import ipv4_pkg::*;
(
  input  logic            clk,
  input  logic            fsm_rst,
  input  ipv4_addr_t      dev_ip,
  input  logic            req_val,
  input  ipv4_req_t       req,
  output logic            req_acc,
  input  logic            done,
  output logic            start,
  output ipv4_hdr_bytes_t hdr_bytes,
  output ipv4_len_t       pld_len,
  output logic            need_arp,
  output mac_addr_t       known_mac,
  output ipv4_addr_t      dst_ip
);

  logic busy;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      busy    <= 1'b0;
      req_acc <= 1'b0;
      start   <= 1'b0;
    end else begin
      req_acc <= 1'b0;
      start   <= req_acc;
      if (!busy && req_val) begin
        req_acc <= 1'b1;
        busy    <= 1'b1;
      end
      if (done) begin
        busy <= 1'b0;
      end
    end
  end

  // ####################################################################
  // Header layout captured while the source still holds the request.
  // ####################################################################

  always_ff @(posedge clk) begin
    if (req_acc) begin
      hdr_bytes[19]    <= 8'h45;
      hdr_bytes[18]    <= req.qos;
      hdr_bytes[17:16] <= req.pld_len + ipv4_len_t'(`IPV4_HDR_LEN);
      hdr_bytes[15:14] <= req.id;
      hdr_bytes[13]    <= {1'b0, req.df, req.mf, req.fo[12:8]};
      hdr_bytes[12]    <= req.fo[7:0];
      hdr_bytes[11]    <= req.ttl;
      hdr_bytes[10]    <= req.proto;
      // Checksum filled in by execute.
      hdr_bytes[9:8]   <= 16'h0000;
      hdr_bytes[7:4]   <= dev_ip;
      hdr_bytes[3:0]   <= req.dst_ip;
      pld_len          <= req.pld_len;
      need_arp         <= !req.mac_known;
      known_mac        <= req.mac;
      dst_ip           <= req.dst_ip;
    end
  end

endmodule

//--- rtl/arp_wb_pkg.sv
package arp_wb_pkg;

  localparam int WB_AW = 8;
  localparam int WB_DW = 32;

  // Entry word 0.
  typedef struct packed {
    logic valid;
    logic [14:0] rsvd;
    logic [15:0] mac_hi;
  } arp_status_t;

  // Entry word 1.
  typedef struct packed {
    logic [31:0] mac_lo;
  } arp_low_t;

  typedef union packed {
    arp_status_t status;
    arp_low_t low;
  } arp_word_u;

endpackage

//--- rtl/ipv4_pkg.sv
`include "ipv4_tx_settings.svh"

package ipv4_pkg;

  // Octet 3 is the first on the wire.
  typedef logic [3:0][7:0] ipv4_addr_t;

  typedef logic [47:0] mac_addr_t;

  typedef logic [15:0] ipv4_len_t;

  typedef logic [12:0] ipv4_fo_t;

  // Header byte 0 sits at index IPV4_HDR_LEN-1.
  typedef logic [`IPV4_HDR_LEN-1:0][7:0] ipv4_hdr_bytes_t;

  typedef struct packed {
    logic [7:0] qos;
    logic [15:0] id;
    logic df;
    logic mf;
    ipv4_fo_t fo;
    logic [7:0] ttl;
    logic [7:0] proto;
    ipv4_addr_t dst_ip;
    ipv4_len_t pld_len;
    logic mac_known;
    mac_addr_t mac;
  } ipv4_req_t;

endpackage

//--- rtl/ipv4_tx_settings.svh
`ifndef IPV4_TX_SETTINGS_SVH
`define IPV4_TX_SETTINGS_SVH

// Fixed IPv4 header without options.
`define IPV4_HDR_LEN 20

// Adder tree of 2**CKS_STAGES words must cover the header.
`define CKS_STAGES 4

// Cycles without ack before a lookup gives up.
`define ARP_TIMEOUT 64

// ARP table layout in Wishbone word addresses.
`define ARP_BASE 8'h40
`define ARP_STRIDE 2
// Low destination IP bits used as table index.
`define ARP_IDX_W 5

`endif
